//--- compile.f
hw/backend_pkg.sv
hw/simple_alu.sv
hw/forwarding_unit.sv
hw/ctrl_pipe.sv
hw/data_pipe.sv
hw/backend_pipeline.sv
tests/tb_backend_pipeline.sv

//--- hw/backend_pipeline.sv
`timescale 1ns/1ps

module backend_pipeline (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    issue_i,
	input  backend_pkg::ctrl_flow_t ctrl_flow_i,
	input  backend_pkg::data_flow_t data_flow_i,
	input  logic [2:0]              stall_vec_i,  // ex, m1, m2
	input  logic [2:0]              clr_vec_i,
	input  backend_pkg::fwd_src_t [backend_pkg::PIPE_NUM-1:0][backend_pkg::FWD_SLOT_NUM-1:0]
	                                forwarding_src_i,
	output backend_pkg::fwd_src_t [backend_pkg::FWD_SLOT_NUM-1:0] forwarding_data_o,
	output logic [backend_pkg::REG_ADDR_W-1:0] reg_w_addr_o,
	output logic [backend_pkg::XLEN-1:0]       reg_w_data_o,
	output logic [3:0]              revert_vector_o
);
	import backend_pkg::*;

	ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;

	ctrl_pipe i_ctrl_pipe (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_i     (issue_i),
		.ctrl_flow_i (ctrl_flow_i),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.ex_ctrl_o   (ex_ctrl),
		.m1_ctrl_o   (m1_ctrl),
		.m2_ctrl_o   (m2_ctrl),
		.wb_ctrl_o   (wb_ctrl)
	);

	data_pipe i_data_pipe (
		.clk               (clk),
		.data_flow_i       (data_flow_i),
		.stall_vec_i       (stall_vec_i),
		.ex_ctrl_i         (ex_ctrl),
		.forwarding_src_i  (forwarding_src_i),
		.forwarding_data_o (forwarding_data_o),
		.wb_result_o       (reg_w_data_o)
	);

	assign reg_w_addr_o    = wb_ctrl.w_reg;  // zero on a bubble
	assign revert_vector_o = {wb_ctrl.revert, m2_ctrl.revert, m1_ctrl.revert, ex_ctrl.revert};

endmodule

//--- hw/backend_pkg.sv
package backend_pkg;

	localparam int XLEN         = 32;
	localparam int REG_ADDR_W   = 5;  // r0 means no write
	localparam int PIPE_NUM     = 2;
	localparam int FWD_SLOT_NUM = 3;  // m1, m2, wb

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LU12I
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_LINK   // pc + 4
	} wb_sel_e;

	// inst[25:0] seen with a 12-bit immediate
	typedef struct packed {
		logic [3:0]  rsv;    // 25:22
		logic [11:0] imm12;  // 21:10
		logic [9:0]  rest;
	} inst_ri12_t;

	// inst[25:0] seen with a 20-bit immediate
	typedef struct packed {
		logic        rsv;    // 25
		logic [19:0] imm20;  // 24:5
		logic [4:0]  rest;
	} inst_ri20_t;

	typedef union packed {
		inst_ri12_t ri12;
		inst_ri20_t ri20;
	} inst_fields_u;

	typedef struct packed {
		logic       pipe_sel;
		logic [3:0] ex_src;  // one-hot: own, m1, m2, wb
	} fwd_info_t;

	typedef struct packed {
		alu_op_e      alu_op;
		logic         use_imm;
		wb_sel_e      wb_sel;
		inst_fields_u inst;
	} decode_t;

	typedef struct packed {
		decode_t                     decode;
		logic [REG_ADDR_W-1:0]       w_reg;
		logic                        revert;
		fwd_info_t [1:0]             fwd;  // [0] rk, [1] rj
	} ctrl_flow_t;

	typedef struct packed {
		logic [XLEN-1:0]           pc;
		logic [1:0][XLEN-1:0]      reg_data;  // [0] rk, [1] rj
		logic [XLEN-1:0]           result;
	} data_flow_t;

	typedef logic [XLEN-1:0] fwd_src_t;

endpackage

//--- hw/ctrl_pipe.sv
`timescale 1ns/1ps

module ctrl_pipe (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    issue_i,
	input  backend_pkg::ctrl_flow_t ctrl_flow_i,
	input  logic [2:0]              stall_vec_i,  // ex, m1, m2
	input  logic [2:0]              clr_vec_i,
	output backend_pkg::ctrl_flow_t ex_ctrl_o,
	output backend_pkg::ctrl_flow_t m1_ctrl_o,
	output backend_pkg::ctrl_flow_t m2_ctrl_o,
	output backend_pkg::ctrl_flow_t wb_ctrl_o
);
	import backend_pkg::*;

	logic [1:0][3:0] ex_src_next;
	logic [1:0]      ex_src_move;

	// while ex waits, a producer that moves on is followed to its next slot
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			ex_src_move[i] = (ex_ctrl_o.fwd[i].ex_src[1] & ~stall_vec_i[1]) |
			                 (ex_ctrl_o.fwd[i].ex_src[2] & ~stall_vec_i[2]) |
			                  ex_ctrl_o.fwd[i].ex_src[3];  // wb always leaves
			if (ex_src_move[i]) begin
				// m1 -> m2, m2 -> wb, wb -> own value
				ex_src_next[i] = {ex_ctrl_o.fwd[i].ex_src[2:1], 1'b0,
				                  ~|ex_ctrl_o.fwd[i].ex_src[2:1]};
			end else begin
				ex_src_next[i] = ex_ctrl_o.fwd[i].ex_src;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl_o <= '0;
		end else if (!stall_vec_i[0]) begin
			if (issue_i) begin
				ex_ctrl_o <= ctrl_flow_i;
			end else begin
				ex_ctrl_o <= '0;  // bubble
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				ex_ctrl_o.fwd[i].ex_src <= ex_src_next[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_ctrl_o <= '0;
		end else if (!stall_vec_i[1]) begin
			if (clr_vec_i[0] | stall_vec_i[0]) begin
				m1_ctrl_o <= '0;
			end else begin
				m1_ctrl_o <= ex_ctrl_o;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_ctrl_o <= '0;
		end else if (!stall_vec_i[2]) begin
			if (clr_vec_i[1] | stall_vec_i[1]) begin
				m2_ctrl_o <= '0;
			end else begin
				m2_ctrl_o <= m1_ctrl_o;
			end
		end
	end

	// wb never holds
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ctrl_o <= '0;
		end else if (clr_vec_i[2] | stall_vec_i[2]) begin
			wb_ctrl_o <= '0;
		end else begin
			wb_ctrl_o <= m2_ctrl_o;
		end
	end

endmodule

//--- hw/data_pipe.sv
`timescale 1ns/1ps

module data_pipe (
	input  logic                    clk,
	input  backend_pkg::data_flow_t data_flow_i,
	input  logic [2:0]              stall_vec_i,
	input  backend_pkg::ctrl_flow_t ex_ctrl_i,
	input  backend_pkg::fwd_src_t [backend_pkg::PIPE_NUM-1:0][backend_pkg::FWD_SLOT_NUM-1:0]
	                                forwarding_src_i,
	output backend_pkg::fwd_src_t [backend_pkg::FWD_SLOT_NUM-1:0] forwarding_data_o,
	output logic [backend_pkg::XLEN-1:0] wb_result_o
);
	import backend_pkg::*;

	data_flow_t           ex_raw;
	data_flow_t           ex_fwd;   // ex view after forwarding
	logic [1:0][XLEN-1:0] ex_opnd;
	logic [XLEN-1:0]      alu_res;
	logic [XLEN-1:0]      m1_result;
	logic [XLEN-1:0]      m2_result;
	logic [XLEN-1:0]      wb_result;

	for (genvar i = 0; i < 2; i++) begin : g_ex_fwd
		forwarding_unit #(
			.SOURCE_NUM (FWD_SLOT_NUM),
			.PIPE_NUM   (PIPE_NUM)
		) i_fwd (
			.pipe_sel_i (ex_ctrl_i.fwd[i].pipe_sel),
			.sel_vec_i  (ex_ctrl_i.fwd[i].ex_src),
			.data_vec_i (forwarding_src_i),
			.old_data_i (ex_raw.reg_data[i]),
			.new_data_o (ex_opnd[i])
		);
	end

	simple_alu i_alu (
		.decode_i  (ex_ctrl_i.decode),
		.rj_i      (ex_opnd[1]),
		.rk_i      (ex_opnd[0]),
		.pc_i      (ex_raw.pc),
		.alu_res_o (alu_res)  // link value comes out here too
	);

	assign ex_fwd = '{pc: ex_raw.pc, reg_data: ex_opnd, result: alu_res};

	// a held ex keeps whatever it has forwarded so far
	always_ff @(posedge clk) begin
		if (!stall_vec_i[0]) begin
			ex_raw <= data_flow_i;
		end else begin
			ex_raw <= ex_fwd;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_vec_i[1]) begin
			m1_result <= ex_fwd.result;
		end
		if (!stall_vec_i[2]) begin
			m2_result <= m1_result;
		end
		wb_result <= m2_result;
	end

	assign forwarding_data_o = {wb_result, m2_result, m1_result};
	assign wb_result_o       = wb_result;

endmodule

//--- hw/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit #(
	parameter int SOURCE_NUM = 3,
	parameter int PIPE_NUM   = backend_pkg::PIPE_NUM
) (
	input  logic [$clog2(PIPE_NUM)-1:0]                       pipe_sel_i,
	input  logic [SOURCE_NUM:0]                               sel_vec_i,  // bit 0 keeps own
	input  backend_pkg::fwd_src_t [PIPE_NUM-1:0][SOURCE_NUM-1:0] data_vec_i,
	input  backend_pkg::fwd_src_t                             old_data_i,
	output backend_pkg::fwd_src_t                             new_data_o
);

	always_comb begin
		new_data_o = old_data_i;
		if (!sel_vec_i[0]) begin
			// one-hot, so at most one slot hits
			for (int i = 0; i < SOURCE_NUM; i++) begin
				if (sel_vec_i[i+1]) begin
					new_data_o = data_vec_i[pipe_sel_i][i];
				end
			end
		end
	end

endmodule

//--- hw/simple_alu.sv
`timescale 1ns/1ps

module simple_alu (
	input  backend_pkg::decode_t            decode_i,
	input  logic [backend_pkg::XLEN-1:0]    rj_i,
	input  logic [backend_pkg::XLEN-1:0]    rk_i,
	input  logic [backend_pkg::XLEN-1:0]    pc_i,
	output logic [backend_pkg::XLEN-1:0]    alu_res_o
);
	import backend_pkg::*;

	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] calc;
	logic [4:0]      shamt;

	// lu12i takes the wide view, everything else the signed 12-bit one
	assign imm = (decode_i.alu_op == ALU_LU12I) ?
		{decode_i.inst.ri20.imm20, 12'd0} :
		{{(XLEN-12){decode_i.inst.ri12.imm12[11]}}, decode_i.inst.ri12.imm12};

	assign op_b  = decode_i.use_imm ? imm : rk_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (decode_i.alu_op)
			ALU_ADD:   calc = rj_i + op_b;
			ALU_SUB:   calc = rj_i - op_b;
			ALU_SLT:   calc = {{(XLEN-1){1'b0}}, $signed(rj_i) < $signed(op_b)};
			ALU_SLTU:  calc = {{(XLEN-1){1'b0}}, rj_i < op_b};
			ALU_AND:   calc = rj_i & op_b;
			ALU_OR:    calc = rj_i | op_b;
			ALU_XOR:   calc = rj_i ^ op_b;
			ALU_SLL:   calc = rj_i << shamt;
			ALU_SRL:   calc = rj_i >> shamt;
			ALU_SRA:   calc = $unsigned($signed(rj_i) >>> shamt);
			ALU_LU12I: calc = op_b;
			default:   calc = '0;
		endcase
	end

	// link writeback bypasses the operation result
	assign alu_res_o = (decode_i.wb_sel == WB_LINK) ? pc_i + 32'd4 : calc;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the backend pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_backend_pipeline

verilator --binary -f compile.f --top-module "$TOP" --Mdir obj_dir -o "V$TOP"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tests/backend_testdata.txt
// num kind op imm wbsel inst wreg revert pc rj rk fwd0(rk) fwd1(rj) fval fpipe
// stall_mask stall_len clr_mask expected ; kind 0 alu 1 link 2 fwd 3 stall 4 clear
01 0 0 0 0 00000000 01 0 00000000 00000005 00000007 01 01 00000000 0 0 0 0 0000000c
02 0 0 1 0 003ffc00 02 0 00000000 00000010 00000000 01 01 00000000 0 0 0 0 0000000f
03 0 1 0 0 00000000 03 0 00000000 00000003 00000005 01 01 00000000 0 0 0 0 fffffffe
04 0 1 1 0 001ffc00 04 0 00000000 00001000 00000000 01 01 00000000 0 0 0 0 00000801
05 0 2 0 0 00000000 05 0 00000000 ffffffff 00000001 01 01 00000000 0 0 0 0 00000001
06 0 2 1 0 00200000 06 0 00000000 00000000 00000000 01 01 00000000 0 0 0 0 00000000
07 0 3 0 0 00000000 07 0 00000000 ffffffff 00000001 01 01 00000000 0 0 0 0 00000000
08 0 3 1 0 003ffc00 08 0 00000000 00000005 00000000 01 01 00000000 0 0 0 0 00000001
09 0 4 0 0 00000000 09 0 00000000 f0f0f0f0 0ff00ff0 01 01 00000000 0 0 0 0 00f000f0
0a 0 4 1 0 0003fc00 0a 0 00000000 12345678 00000000 01 01 00000000 0 0 0 0 00000078
0b 0 5 0 0 00000000 0b 0 00000000 12340000 00005678 01 01 00000000 0 0 0 0 12345678
0c 0 5 1 0 00200000 0c 0 00000000 000000ff 00000000 01 01 00000000 0 0 0 0 fffff8ff
0d 0 6 0 0 00000000 0d 0 00000000 aaaaaaaa ffff0000 01 01 00000000 0 0 0 0 5555aaaa
0e 0 6 1 0 00155400 0e 0 00000000 00000fff 00000000 01 01 00000000 0 0 0 0 00000aaa
0f 0 7 0 0 00000000 0f 0 00000000 00000001 00000024 01 01 00000000 0 0 0 0 00000010
10 0 7 1 0 00007c00 10 0 00000000 00000003 00000000 01 01 00000000 0 0 0 0 80000000
11 0 8 0 0 00000000 11 0 00000000 80000000 00000004 01 01 00000000 0 0 0 0 08000000
12 0 9 1 0 00002000 12 0 00000000 80000000 00000000 01 01 00000000 0 0 0 0 ff800000
13 0 9 0 0 00000000 13 0 00000000 7fff0000 00000010 01 01 00000000 0 0 0 0 00007fff
14 0 a 1 0 002468a0 14 0 00000000 00000077 00000000 01 01 00000000 0 0 0 0 12345000
15 1 0 0 1 00000000 15 1 00001000 00000001 00000002 01 01 00000000 0 0 0 0 00001004
16 2 0 0 0 00000000 16 0 00000000 00000001 0000dead 02 01 00000100 0 0 0 0 00000101
17 2 1 0 0 00000000 17 0 00000000 00000055 00000002 01 18 00000300 1 0 0 0 000002fe
18 2 0 0 0 00000000 18 0 00000000 00000011 00000022 14 14 00000040 1 0 0 0 00000080
19 3 0 0 0 00000000 19 0 00000000 00000001 0000beef 02 01 00000020 0 1 4 0 00000021
1a 3 5 0 0 00000000 1a 0 00000000 000000f0 0000000f 01 01 00000000 0 2 3 0 000000ff
1b 3 1 0 0 00000000 1b 0 00000000 00000010 00000001 01 01 00000000 0 4 5 0 0000000f
1c 4 0 0 0 00000000 1c 0 00000000 00000001 00000001 01 01 00000000 0 0 0 1 00000000
1d 4 0 0 0 00000000 1d 0 00000000 00000002 00000002 01 01 00000000 0 0 0 2 00000000
1e 4 0 0 0 00000000 1e 0 00000000 00000003 00000003 01 01 00000000 0 0 0 4 00000000

//--- tests/tb_backend_pipeline.sv
`timescale 1ns/1ps

module tb_backend_pipeline;
	import backend_pkg::*;

	localparam int FIELDS   = 19;  // words per line of the data file
	localparam int MAX_CASE = 40;
	localparam int TIMEOUT  = 50;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       issue_i;
	ctrl_flow_t ctrl_flow_i;
	data_flow_t data_flow_i;
	logic [2:0] stall_vec_i;
	logic [2:0] clr_vec_i;
	fwd_src_t [PIPE_NUM-1:0][FWD_SLOT_NUM-1:0] forwarding_src_i;
	fwd_src_t [FWD_SLOT_NUM-1:0]               forwarding_data_o;
	logic [REG_ADDR_W-1:0] reg_w_addr_o;
	logic [XLEN-1:0]       reg_w_data_o;
	logic [3:0]            revert_vector_o;

	logic [31:0] td [0:MAX_CASE*FIELDS-1];
	int pass_cnt = 0;
	int fail_cnt = 0;

	always #10 clk = ~clk;

	backend_pipeline i_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.issue_i           (issue_i),
		.ctrl_flow_i       (ctrl_flow_i),
		.data_flow_i       (data_flow_i),
		.stall_vec_i       (stall_vec_i),
		.clr_vec_i         (clr_vec_i),
		.forwarding_src_i  (forwarding_src_i),
		.forwarding_data_o (forwarding_data_o),
		.reg_w_addr_o      (reg_w_addr_o),
		.reg_w_data_o      (reg_w_data_o),
		.revert_vector_o   (revert_vector_o)
	);

	// stage index of a one-hot stage mask
	function automatic int stage_of(input logic [2:0] mask);
		if (mask[0]) return 0;
		if (mask[1]) return 1;
		return 2;
	endfunction

	task automatic run_case(input int b);
		int          num;
		int          errs;
		int          wr_cnt;
		int          wcyc;
		int          st_k;
		int          clr_k;
		int          len;
		logic [2:0]  st_mask;
		logic [2:0]  clr_mask;
		logic [31:0] fval;
		logic        fpipe;
		logic [31:0] expect_data;
		num         = td[b];
		errs        = 0;
		wr_cnt      = 0;
		wcyc        = 0;
		fval        = td[b+13];
		fpipe       = td[b+14][0];
		st_mask     = td[b+15][2:0];
		len         = td[b+16];
		clr_mask    = td[b+17][2:0];
		expect_data = td[b+18];
		st_k        = stage_of(st_mask);
		clr_k       = stage_of(clr_mask);
		if (st_mask == 3'b000) len = 0;
		// all slots of the chosen pipe carry the value, the other pipe differs
		for (int s = 0; s < FWD_SLOT_NUM; s++) begin
			forwarding_src_i[fpipe][s]  = fval;
			forwarding_src_i[!fpipe][s] = ~fval;
		end
		ctrl_flow_i                = '0;
		ctrl_flow_i.decode.alu_op  = alu_op_e'(td[b+2][3:0]);
		ctrl_flow_i.decode.use_imm = td[b+3][0];
		ctrl_flow_i.decode.wb_sel  = wb_sel_e'(td[b+4][0]);
		ctrl_flow_i.decode.inst    = td[b+5][25:0];
		ctrl_flow_i.w_reg          = td[b+6][REG_ADDR_W-1:0];
		ctrl_flow_i.revert         = td[b+7][0];
		ctrl_flow_i.fwd[0]         = td[b+11][4:0];
		ctrl_flow_i.fwd[1]         = td[b+12][4:0];
		data_flow_i.pc             = td[b+8];
		data_flow_i.reg_data[1]    = td[b+9];
		data_flow_i.reg_data[0]    = td[b+10];
		data_flow_i.result         = '0;
		issue_i                    = 1'b1;
		for (int n = 0; n < TIMEOUT; n++) begin
			@(posedge clk);
			#1;
			if (len == 0 && clr_mask == 3'b000 && n < 3) begin
				// a lone instruction, so only its own stage carries the flag
				if (revert_vector_o !== (4'(ctrl_flow_i.revert) << n)) begin
					$display("CHECK FAILED revert_vector_o expected %h got %h",
						4'(ctrl_flow_i.revert) << n, revert_vector_o);
					errs++;
				end
				if (n > 0 && forwarding_data_o[n-1] !== expect_data) begin
					$display("CHECK FAILED forwarding_data_o[%0d] expected %h got %h",
						n - 1, expect_data, forwarding_data_o[n-1]);
					errs++;
				end
			end
			if (reg_w_addr_o == ctrl_flow_i.w_reg) begin
				wr_cnt++;
				if (clr_mask != 3'b000) begin
					$display("test %0d: cleared instruction was written at cycle %0d", num, n);
					errs++;
				end else if (wr_cnt > 1) begin
					$display("test %0d: write held for more than one cycle", num);
					errs++;
				end else begin
					wcyc = n;
					if (n != 3 + len) begin
						$display("test %0d: write at cycle %0d instead of %0d", num, n, 3 + len);
						errs++;
					end
					if (reg_w_data_o !== expect_data) begin
						$display("CHECK FAILED reg_w_data_o expected %h got %h",
							expect_data, reg_w_data_o);
						errs++;
					end
					if (forwarding_data_o[2] !== expect_data) begin
						$display("CHECK FAILED forwarding_data_o[2] expected %h got %h",
							expect_data, forwarding_data_o[2]);
						errs++;
					end
					if (revert_vector_o[3] !== ctrl_flow_i.revert) begin
						$display("CHECK FAILED revert_vector_o[3] expected %h got %h",
							ctrl_flow_i.revert, revert_vector_o[3]);
						errs++;
					end
				end
			end
			#1;
			if (wr_cnt > 0 && n == wcyc + 1) break;  // one cycle after the write
			issue_i     = 1'b0;
			stall_vec_i = (n >= st_k && n < st_k + len) ? st_mask : 3'b000;
			clr_vec_i   = (n == clr_k) ? clr_mask : 3'b000;
		end
		if (wr_cnt == 0 && clr_mask == 3'b000) begin
			$display("test %0d: no register write seen within %0d cycles", num, TIMEOUT);
			errs++;
		end
		issue_i     = 1'b0;
		stall_vec_i = '0;
		clr_vec_i   = '0;
		if (errs == 0) begin
			pass_cnt++;
			$display("test %0d kind %0d: ok", num, td[b+1]);
		end else begin
			fail_cnt++;
			$display("test %0d kind %0d: FAILED", num, td[b+1]);
		end
	endtask

	initial begin
		int idx;
		rst_n            = 1'b0;
		issue_i          = 1'b0;
		ctrl_flow_i      = '0;
		data_flow_i      = '0;
		stall_vec_i      = '0;
		clr_vec_i        = '0;
		forwarding_src_i = '0;
		for (int i = 0; i < MAX_CASE*FIELDS; i++) begin
			td[i] = ~32'(i);  // words past the last data line keep this
		end
		$readmemh("tests/backend_testdata.txt", td);
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		if (reg_w_addr_o !== '0 || revert_vector_o !== 4'h0) begin
			$display("CHECK FAILED reg_w_addr_o/revert_vector_o expected 00/0 got %h/%h",
				reg_w_addr_o, revert_vector_o);
			fail_cnt++;
			$display("test 0 reset: FAILED");
		end else begin
			pass_cnt++;
			$display("test 0 reset: ok");
		end
		#1;
		idx = 0;
		while (idx < MAX_CASE && td[idx*FIELDS] !== ~32'(idx*FIELDS)) begin
			run_case(idx * FIELDS);
			idx++;
		end
		$display("passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
